// ==== source/icache_pkg.sv ====
//////////////////////////////
// Shared geometry and state types for the instruction cache
// Imported by every cache block
//////////////////////////////

package icache_pkg;

    //////////////////////////////
    // Word and address widths
    //////////////////////////////

    // Instruction word width
    localparam int XLEN = 32;
    // Fetch and memory address width
    localparam int ADDR_W = 32;

    //////////////////////////////
    // Cache geometry
    //////////////////////////////

    // Line payload in bits
    localparam int LINE_W = 128;
    localparam int WORDS_PER_LINE = LINE_W / XLEN;
    // Byte offset bits inside one line
    localparam int OFFSET_W = $clog2(LINE_W / 8);
    // Number of lines, direct mapped
    localparam int DEPTH = 16;
    localparam int INDEX_W = $clog2(DEPTH);
    // Remaining upper address bits
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    //////////////////////////////
    // Memory read channel
    //////////////////////////////

    // One instruction word per beat
    localparam int MEM_DATA_W = 32;
    // AXI arlen encoding, beats minus one
    localparam int BURST_LEN = (LINE_W / MEM_DATA_W) - 1;

    // Fill and flush sequencer states
    typedef enum logic [2:0] {
        FILL_IDLE,
        FILL_ADDR,
        FILL_DATA,
        FILL_WRITE,
        FILL_FLUSH
    } fill_state_t;

endpackage

// ==== source/icache_lines.sv ====
`timescale 1ns/10ps

//////////////////////////////
// Line storage with tag and valid arrays
// Registered lookup gives one-cycle hit or miss strobes
//////////////////////////////

module icache_lines (
    input  logic                           aclk,
    input  logic                           rst_n,
    // Lookup side
    input  logic                           lookup_en,
    input  logic [icache_pkg::ADDR_W-1:0]  lookup_addr,
    // Line write from the fill sequencer
    input  logic                           wen,
    input  logic [icache_pkg::ADDR_W-1:0]  waddr,
    input  logic [icache_pkg::LINE_W-1:0]  wdata,
    // Flush walker
    input  logic                           flush_en,
    input  logic [icache_pkg::INDEX_W-1:0] flush_index,
    // Lookup result
    output logic                           hit,
    output logic                           miss,
    output logic [icache_pkg::LINE_W-1:0]  line_data,
    output logic [1:0]                     word_sel
);

    import icache_pkg::*;

    //////////////////////////////
    // Storage and address fields
    //////////////////////////////

    // Line payload, tag and valid per index
    logic [LINE_W-1:0]  data_mem [DEPTH];
    logic [TAG_W-1:0]   tag_mem  [DEPTH];
    logic [DEPTH-1:0]   valid_bits;

    // Fields of the fetch address
    logic [TAG_W-1:0]   lk_tag;
    logic [INDEX_W-1:0] lk_index;
    // Fields of the fill address
    logic [TAG_W-1:0]   wr_tag;
    logic [INDEX_W-1:0] wr_index;
    // Stored line matches the fetch address
    logic               tag_match;

    assign lk_tag   = lookup_addr[ADDR_W-1 -: TAG_W];
    assign lk_index = lookup_addr[OFFSET_W +: INDEX_W];
    assign wr_tag   = waddr[ADDR_W-1 -: TAG_W];
    assign wr_index = waddr[OFFSET_W +: INDEX_W];

    // Hit needs a valid entry and an equal tag
    assign tag_match = valid_bits[lk_index] && (tag_mem[lk_index] == lk_tag);

    //////////////////////////////
    // Array writes
    //////////////////////////////

    // Whole line and its tag land in one cycle
    always_ff @(posedge aclk) begin
        if (wen) begin
            data_mem[wr_index] <= wdata;
            tag_mem[wr_index]  <= wr_tag;
        end
    end

    // Walker clears one entry per cycle, fill marks its line valid
    always_ff @(posedge aclk) begin
        if (flush_en) begin
            valid_bits[flush_index] <= 1'b0;
        end else if (wen) begin
            valid_bits[wr_index] <= 1'b1;
        end
    end

    //////////////////////////////
    // Registered lookup
    //////////////////////////////

    // Strobes last one cycle per accepted lookup
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            hit  <= 1'b0;
            miss <= 1'b0;
        end else begin
            hit  <= lookup_en && tag_match;
            miss <= lookup_en && !tag_match;
        end
    end

    // Line and word select follow the strobe into the answer stage
    always_ff @(posedge aclk) begin
        if (lookup_en) begin
            line_data <= data_mem[lk_index];
            // Word index sits just above the byte bits
            word_sel  <= lookup_addr[OFFSET_W-1 -: 2];
        end
    end

endmodule

// ==== source/icache_fill.sv ====
`timescale 1ns/10ps

//////////////////////////////
// Miss fill and flush sequencer
// Issues one read burst per miss, walks the valid bits on flush
//////////////////////////////

module icache_fill (
    input  logic                              aclk,
    input  logic                              rst_n,
    // Software flush handshake
    input  logic                              flush_req,
    output logic                              flush_ack,
    // Miss strobe from the lookup stage
    input  logic                              miss,
    input  logic [icache_pkg::ADDR_W-1:0]     miss_addr,
    // Lookup gate
    output logic                              busy,
    // Flush writes to the valid array
    output logic                              flush_en,
    output logic [icache_pkg::INDEX_W-1:0]    flush_index,
    // Line write to storage
    output logic                              wen,
    output logic [icache_pkg::ADDR_W-1:0]     waddr,
    output logic [icache_pkg::LINE_W-1:0]     wdata,
    // Memory read address channel
    output logic                              arvalid,
    input  logic                              arready,
    output logic [icache_pkg::ADDR_W-1:0]     araddr,
    output logic [7:0]                        arlen,
    // Memory read data channel
    input  logic                              rvalid,
    output logic                              rready,
    input  logic [icache_pkg::MEM_DATA_W-1:0] rdata,
    input  logic                              rlast
);

    import icache_pkg::*;

    //////////////////////////////
    // State and datapath
    //////////////////////////////

    fill_state_t        state;
    // Line-aligned address of the pending fill
    logic [ADDR_W-1:0]  fill_addr;
    // Beats shift in from the top, first beat ends at the bottom
    logic [LINE_W-1:0]  line_buf;
    // Index being cleared by the walker
    logic [INDEX_W-1:0] walk_index;
    // Walk was started by software and owes an acknowledge
    logic               walk_by_req;

    logic               flush_take;
    logic               beat_take;
    logic               last_index;

    // Request still high during its own ack cycle is not taken again
    assign flush_take = flush_req && !flush_ack;
    assign beat_take  = rvalid && rready;
    assign last_index = (walk_index == INDEX_W'(DEPTH - 1));

    //////////////////////////////
    // Sequencer
    //////////////////////////////

    // Reset enters the walk so every valid bit gets cleared
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state       <= FILL_FLUSH;
            walk_index  <= '0;
            walk_by_req <= 1'b0;
            flush_ack   <= 1'b0;
        end else begin
            // Ack is a single pulse
            flush_ack <= 1'b0;
            case (state)
                FILL_IDLE: begin
                    // A miss in flight is served before a flush
                    if (miss) begin
                        state <= FILL_ADDR;
                    end else if (flush_take) begin
                        state       <= FILL_FLUSH;
                        walk_index  <= '0;
                        walk_by_req <= 1'b1;
                    end
                end
                FILL_ADDR: begin
                    // Hold the address until the memory takes it
                    if (arready) begin
                        state <= FILL_DATA;
                    end
                end
                FILL_DATA: begin
                    // Gaps in rvalid just wait here
                    if (beat_take && rlast) begin
                        state <= FILL_WRITE;
                    end
                end
                FILL_WRITE: begin
                    // Line is written this cycle, then the held fetch is looked up again
                    state <= FILL_IDLE;
                end
                FILL_FLUSH: begin
                    walk_index <= walk_index + 1'b1;
                    if (last_index) begin
                        state       <= FILL_IDLE;
                        flush_ack   <= walk_by_req;
                        walk_by_req <= 1'b0;
                    end
                end
                default: begin
                    state <= FILL_IDLE;
                end
            endcase
        end
    end

    // Capture the missing line base when the fill starts
    always_ff @(posedge aclk) begin
        if ((state == FILL_IDLE) && miss) begin
            fill_addr <= {miss_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        end
    end

    // One word per accepted beat
    always_ff @(posedge aclk) begin
        if (beat_take) begin
            line_buf <= {rdata, line_buf[LINE_W-1:MEM_DATA_W]};
        end
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    assign arvalid = (state == FILL_ADDR);
    assign araddr  = fill_addr;
    // Fixed four-beat burst
    assign arlen   = 8'(BURST_LEN);
    assign rready  = (state == FILL_DATA);

    assign wen   = (state == FILL_WRITE);
    assign waddr = fill_addr;
    assign wdata = line_buf;

    assign flush_en    = (state == FILL_FLUSH);
    assign flush_index = walk_index;

    // Also covers the miss strobe cycle and a flush about to start
    assign busy = (state != FILL_IDLE) || miss || flush_take;

endmodule

// ==== source/icache_resp.sv ====
`timescale 1ns/10ps

//////////////////////////////
// Answer stage, picks the fetched word and pulses inst_ready
//////////////////////////////

module icache_resp (
    input  logic                          aclk,
    input  logic                          rst_n,
    // Lookup result
    input  logic                          hit,
    input  logic [icache_pkg::LINE_W-1:0] line_data,
    input  logic [1:0]                    word_sel,
    // Fetch answer
    output logic [icache_pkg::XLEN-1:0]   inst_rdata,
    output logic                          inst_ready,
    // Answer in flight, blocks a second lookup of the held fetch
    output logic                          pending
);

    import icache_pkg::*;

    // Word picked out of the line
    logic [XLEN-1:0] word;

    // Word mux over the line
    always_comb begin
        word = line_data[XLEN-1:0];
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            if (word_sel == 2'(w)) begin
                word = line_data[w*XLEN +: XLEN];
            end
        end
    end

    // Ready pulse one cycle after the hit strobe
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            inst_ready <= 1'b0;
        end else begin
            inst_ready <= hit;
        end
    end

    // Data held until the next hit
    always_ff @(posedge aclk) begin
        if (hit) begin
            inst_rdata <= word;
        end
    end

    // Requester still holds the old address through the ready cycle
    assign pending = hit || inst_ready;

endmodule

// ==== source/icache_top.sv ====
`timescale 1ns/10ps

//////////////////////////////
// Instruction cache top, fetch port in and AXI read channel out
//////////////////////////////

module icache_top (
    input  logic                              aclk,
    input  logic                              rst_n,
    // Software flush
    input  logic                              flush_req,
    output logic                              flush_ack,
    // Fetch port
    input  logic                              inst_en,
    input  logic [icache_pkg::ADDR_W-1:0]     inst_addr,
    output logic [icache_pkg::XLEN-1:0]       inst_rdata,
    output logic                              inst_ready,
    // Central memory read channel
    output logic                              arvalid,
    input  logic                              arready,
    output logic [icache_pkg::ADDR_W-1:0]     araddr,
    output logic [7:0]                        arlen,
    input  logic                              rvalid,
    output logic                              rready,
    input  logic [icache_pkg::MEM_DATA_W-1:0] rdata,
    input  logic                              rlast
);

    import icache_pkg::*;

    //////////////////////////////
    // Internal wires
    //////////////////////////////

    logic               lookup_en;
    logic               hit;
    logic               miss;
    logic [LINE_W-1:0]  line_data;
    logic [1:0]         word_sel;
    logic               pending;
    logic               busy;
    logic               wen;
    logic [ADDR_W-1:0]  waddr;
    logic [LINE_W-1:0]  wdata;
    logic               flush_en;
    logic [INDEX_W-1:0] flush_index;

    // One lookup per held fetch, none while filling or flushing
    assign lookup_en = inst_en && !pending && !busy;

    icache_lines u_lines (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .lookup_en   (lookup_en),
        .lookup_addr (inst_addr),
        .wen         (wen),
        .waddr       (waddr),
        .wdata       (wdata),
        .flush_en    (flush_en),
        .flush_index (flush_index),
        .hit         (hit),
        .miss        (miss),
        .line_data   (line_data),
        .word_sel    (word_sel)
    );

    // Fetch address is held stable, so it doubles as the miss address
    icache_fill u_fill (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .flush_req   (flush_req),
        .flush_ack   (flush_ack),
        .miss        (miss),
        .miss_addr   (inst_addr),
        .busy        (busy),
        .flush_en    (flush_en),
        .flush_index (flush_index),
        .wen         (wen),
        .waddr       (waddr),
        .wdata       (wdata),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .arlen       (arlen),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rlast       (rlast)
    );

    icache_resp u_resp (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .hit        (hit),
        .line_data  (line_data),
        .word_sel   (word_sel),
        .inst_rdata (inst_rdata),
        .inst_ready (inst_ready),
        .pending    (pending)
    );

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/10ps

//////////////////////////////
// Testbench clock and reset, 10 ns period
//////////////////////////////

module tb_clock (
    output logic aclk,
    output logic rst_n
);

    localparam int RESET_CYCLES = 4;

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
    end

endmodule

// ==== verification/icache_checker.sv ====
`timescale 1ns/10ps

//////////////////////////////
// Watches the DUT ports, checks answers and bus traffic per test
//////////////////////////////

module icache_checker (
    input  logic        aclk,
    input  logic        inst_en,
    input  logic [31:0] inst_addr,
    input  logic        exp_hit,
    input  logic        inst_ready,
    input  logic [31:0] inst_rdata,
    input  logic        flush_req,
    input  logic        flush_ack,
    input  logic        arvalid,
    input  logic        arready,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic        rvalid,
    input  logic        rready,
    output int          tests_done,
    output int          error_count
);

    import icache_pkg::*;

    localparam logic [31:0] MEM_PATTERN = 32'h5A5A_0000;

    // Test in progress and what it expects
    logic        fetch_on = 1'b0;
    logic        flush_on = 1'b0;
    logic [31:0] f_addr;
    logic        f_hit;
    int          f_cycles;
    int          fl_cycles;
    int          ar_cnt;
    int          beat_cnt;
    int          test_errs;

    initial begin
        tests_done  = 0;
        error_count = 0;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        test_errs++;
        error_count++;
    endtask

    task automatic log_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        test_errs++;
        error_count++;
    endtask

    always @(posedge aclk) begin
        if (fetch_on) f_cycles++;
        if (flush_on) fl_cycles++;
        // Nothing answers or reads memory unasked, reset included
        if (inst_ready && !fetch_on) log_failure("inst_ready pulsed with no fetch outstanding");
        if (flush_ack && !flush_on) log_failure("flush_ack pulsed with no flush outstanding");
        if (arvalid && !fetch_on) log_failure("arvalid raised with no fetch outstanding");
        if (inst_en && !fetch_on) begin
            fetch_on  = 1'b1;
            f_cycles  = 0;
            f_addr    = inst_addr;
            f_hit     = exp_hit;
            ar_cnt    = 0;
            beat_cnt  = 0;
            test_errs = 0;
        end
        if (flush_req && !flush_on) begin
            flush_on  = 1'b1;
            fl_cycles = 0;
            test_errs = 0;
        end
        // Burst must fetch the whole aligned line
        if (fetch_on && arvalid && arready) begin
            ar_cnt++;
            if (araddr !== (f_addr & ~32'hF)) report_mismatch("araddr", araddr, f_addr & ~32'hF);
            if (arlen !== 8'd3) report_mismatch("arlen", 32'(arlen), 32'd3);
        end
        if (fetch_on && rvalid && rready) beat_cnt++;
        if (fetch_on && inst_ready) begin
            if (inst_rdata !== ((f_addr & ~32'h3) ^ MEM_PATTERN)) begin
                report_mismatch("inst_rdata", inst_rdata, (f_addr & ~32'h3) ^ MEM_PATTERN);
            end
            if (f_hit) begin
                if (ar_cnt != 0) log_failure("a hit was expected but the cache read memory");
                if (f_cycles != 2) report_mismatch("inst_ready latency", f_cycles, 2);
            end else begin
                if (ar_cnt != 1) report_mismatch("address handshakes", ar_cnt, 1);
                if (beat_cnt != 4) report_mismatch("read beats", beat_cnt, 4);
            end
            tests_done++;
            $display("test %0d fetch %h %s: %s", tests_done, f_addr, f_hit ? "hit" : "miss",
                     test_errs == 0 ? "ok" : "failed");
            fetch_on = 1'b0;
        end
        // Ack comes DEPTH+1 cycles after the request is taken
        if (flush_on && flush_ack) begin
            if (fl_cycles != DEPTH + 1) report_mismatch("flush_ack latency", fl_cycles, DEPTH + 1);
            tests_done++;
            $display("test %0d flush: %s", tests_done, test_errs == 0 ? "ok" : "failed");
            flush_on = 1'b0;
        end
    end

endmodule

// ==== verification/icache_props.sv ====
`timescale 1ns/10ps

//////////////////////////////
// Read channel and flush assertions, bound into icache_fill
//////////////////////////////

module icache_props (
    input logic                          aclk,
    input logic                          rst_n,
    input logic                          arvalid,
    input logic                          arready,
    input logic [icache_pkg::ADDR_W-1:0] araddr,
    input logic                          rvalid,
    input logic                          rready,
    input logic                          rlast,
    input logic                          flush_ack
);

    // Count of failed assertions
    int assert_fails = 0;

    // Address stays offered and unchanged until taken
    ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
        assert_fails++;
        $error("arvalid or araddr changed before the address was accepted");
    end

    // Data phase opens only on the address handshake
    r_open: assert property (@(posedge aclk) disable iff (!rst_n)
        $rose(rready) |-> $past(arvalid && arready))
    else begin
        assert_fails++;
        $error("rready raised without an accepted address");
    end

    // Data phase closes right after the last beat
    r_close: assert property (@(posedge aclk) disable iff (!rst_n)
        rvalid && rready && rlast |=> !rready)
    else begin
        assert_fails++;
        $error("rready still high after the last beat");
    end

    ack_pulse: assert property (@(posedge aclk) disable iff (!rst_n)
        flush_ack |=> !flush_ack)
    else begin
        assert_fails++;
        $error("flush_ack held longer than one cycle");
    end

endmodule

bind icache_fill icache_props u_props (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .rvalid    (rvalid),
    .rready    (rready),
    .rlast     (rlast),
    .flush_ack (flush_ack)
);

// ==== verification/icache_tb.sv ====
`timescale 1ns/10ps

//////////////////////////////
// Top testbench, replays the stim file against a memory model
// with random arready and rvalid gaps
//////////////////////////////

module icache_tb;

    import icache_pkg::*;

    localparam int MAX_TESTS = 32;
    // Memory word at address A reads as A xor this
    localparam logic [31:0] MEM_PATTERN = 32'h5A5A_0000;

    logic        aclk;
    logic        rst_n;
    logic        flush_req;
    logic        flush_ack;
    logic        inst_en;
    logic        exp_hit;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic        inst_ready;
    logic        arvalid;
    logic        arready = 1'b0;
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic        rvalid = 1'b0;
    logic        rready;
    logic [31:0] rdata = '0;
    logic        rlast = 1'b0;

    // One test per word, op nibble, hit nibble, address
    logic [39:0] stim_mem [MAX_TESTS];
    int          n_tests;
    int          limit;
    int          cycle_count = 0;
    int          tests_done;
    int          error_count;
    int          total_errors;

    // Memory model state
    logic [31:0] rnd = 32'h5155;
    logic [31:0] burst_base = '0;
    int          beat_cnt = 0;
    logic        burst_on = 1'b0;
    logic        ar_hs = 1'b0;
    logic        r_hs = 1'b0;

    tb_clock u_clock (.aclk(aclk), .rst_n(rst_n));

    icache_top u_icache_top (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .flush_req  (flush_req),
        .flush_ack  (flush_ack),
        .inst_en    (inst_en),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .inst_ready (inst_ready),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .arlen      (arlen),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rlast      (rlast)
    );

    icache_checker u_checker (
        .aclk        (aclk),
        .inst_en     (inst_en),
        .inst_addr   (inst_addr),
        .exp_hit     (exp_hit),
        .inst_ready  (inst_ready),
        .inst_rdata  (inst_rdata),
        .flush_req   (flush_req),
        .flush_ack   (flush_ack),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .arlen       (arlen),
        .rvalid      (rvalid),
        .rready      (rready),
        .tests_done  (tests_done),
        .error_count (error_count)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    //////////////////////////////
    // Memory model
    //////////////////////////////

    // Handshakes as seen by the DUT at the rising edge
    always @(posedge aclk) begin
        ar_hs <= arvalid && arready;
        r_hs  <= rvalid && rready;
        if (arvalid && arready) begin
            burst_base <= araddr;
        end
    end

    always @(negedge aclk) begin
        if (ar_hs) begin
            beat_cnt = 0;
            burst_on = 1'b1;
        end
        if (r_hs) begin
            beat_cnt = beat_cnt + 1;
            burst_on = (beat_cnt < 4);
        end
        rnd = next_random(rnd);
        arready = rnd[3];
        // A beat on offer stays until taken
        if (!burst_on) begin
            rvalid = 1'b0;
        end else if (!rvalid || r_hs) begin
            rvalid = rnd[9];
        end
        rdata = (burst_base + 32'(beat_cnt * 4)) ^ MEM_PATTERN;
        rlast = (beat_cnt == 3);
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    task automatic issue_fetch(input logic [31:0] addr, input logic hit);
        @(negedge aclk);
        inst_addr = addr;
        exp_hit   = hit;
        inst_en   = 1'b1;
        do @(negedge aclk); while (!inst_ready);
        inst_en = 1'b0;
    endtask

    task automatic request_flush();
        @(negedge aclk);
        flush_req = 1'b1;
        do @(negedge aclk); while (!flush_ack);
        flush_req = 1'b0;
    endtask

    // Run limit grows with the number of tests
    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > limit) begin
            $display("timeout: the cache did not answer within %0d cycles", limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        flush_req = 1'b0;
        inst_en   = 1'b0;
        exp_hit   = 1'b0;
        inst_addr = '0;
        for (int i = 0; i < MAX_TESTS; i++) begin
            stim_mem[i] = '1;
        end
        $readmemh("verification/icache_stim.txt", stim_mem);
        n_tests = 0;
        while (n_tests < MAX_TESTS && stim_mem[n_tests][39:36] != 4'hF) begin
            n_tests++;
        end
        limit = n_tests * 64 + DEPTH + 20;
        @(posedge rst_n);
        for (int t = 0; t < n_tests; t++) begin
            if (stim_mem[t][39:36] == 4'h1) begin
                request_flush();
            end else begin
                issue_fetch(stim_mem[t][31:0], stim_mem[t][32]);
            end
        end
        // Let the checker log the last answer
        repeat (3) @(negedge aclk);
        total_errors = error_count + u_icache_top.u_fill.u_props.assert_fails;
        if (tests_done != n_tests) begin
            $display("only %0d of %0d tests finished", tests_done, n_tests);
        end
        $display("tests %0d of %0d, errors %0d", tests_done, n_tests, total_errors);
        if (total_errors == 0 && tests_done == n_tests) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
source/icache_pkg.sv
source/icache_lines.sv
source/icache_fill.sv
source/icache_resp.sv
source/icache_top.sv
verification/tb_clock.sv
verification/icache_checker.sv
verification/icache_props.sv
verification/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module icache_tb -o icache_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/icache_sim +verilator+error+limit+1000 > sim.log 2>&1 ; cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || exit 1
exit 0

// ==== verification/icache_stim.txt ====
// op_hit_address: op 0 fetch, 1 flush, F end of tests
// hit 1 when the fetch should hit, address in hex
0_0_00000100
0_1_00000104
0_1_00000108
0_1_0000010C
0_1_00000100
0_0_00000210
0_1_00000214
0_0_00001100
0_0_00000104
0_0_00001108
0_1_00000218
1_0_00000000
0_0_00000210
0_1_0000021C
0_0_00001108
0_0_000003F0
0_1_000003FC
0_0_0000A3F4
1_0_00000000
1_0_00000000
0_0_0000A3F8
F_0_00000000
